// File: Makefile
SRCS := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)

.PHONY: compile run clean

compile: obj_dir/Vrom_loader_tb

obj_dir/Vrom_loader_tb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module rom_loader_tb -f project.f

# the log decides, a missing pass line fails the target
run: compile
	./obj_dir/Vrom_loader_tb | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
+incdir+verilog
verilog/rom_loader_pkg.sv
verilog/rom_dwnld.sv
verilog/hdr_regs.sv
verilog/sdram_prog.sv
verilog/prom_store.sv
verilog/rom_loader_top.sv
test/rom_loader_chk.sv
test/rom_loader_tb.sv

// File: test/rom_loader_chk.sv
`timescale 1ns/10ps

module rom_loader_chk (
    input logic clk,
    input logic rst_n,
    input logic downloading,
    input logic ioctl_wr,
    input logic prog_we,
    input logic prom_we,
    input logic sdram_ack,
    input logic header
);

    // number of assertion failures so far
    int fails = 0;

    // a byte goes either to SDRAM or to the PROM, never to both
    strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(prog_we && prom_we))
    else begin
        fails++;
        $error("prog_we and prom_we are high in the same cycle");
    end

    // the request is dropped the cycle after the port takes it
    ack_clears: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_ack |=> !prog_we)
    else begin
        fails++;
        $error("prog_we still high one cycle after sdram_ack");
    end

    // header bytes and writes outside a download never start a request
    hdr_no_req: assert property (@(posedge clk) disable iff (!rst_n)
        ioctl_wr && (header || !downloading) |=> !$rose(prog_we) && !$rose(prom_we))
    else begin
        fails++;
        $error("a header byte or a write outside a download started a request");
    end

endmodule

bind rom_dwnld rom_loader_chk chk_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .ioctl_wr    (ioctl_wr),
    .prog_we     (prog_we),
    .prom_we     (prom_we),
    .sdram_ack   (sdram_ack),
    .header      (header)
);

// File: test/rom_loader_tb.sv
`timescale 1ns/10ps
`include "rom_loader_settings.svh"

module rom_loader_tb;

    localparam int SDRAM_AW = `ROM_SDRAM_AW;
    localparam int PROM_AW  = `ROM_PROM_AW;
    localparam rom_loader_pkg::ioctl_addr_t HDR_LEN    = `ROM_HEADER_LEN;
    localparam rom_loader_pkg::ioctl_addr_t BA1_START  = `ROM_BA1_START;
    localparam rom_loader_pkg::ioctl_addr_t BA2_START  = `ROM_BA2_START;
    localparam rom_loader_pkg::ioctl_addr_t BA3_START  = `ROM_BA3_START;
    localparam rom_loader_pkg::ioctl_addr_t PROM_START = `ROM_PROM_START;
    localparam logic SWAB = 1'(`ROM_SWAB);

    logic                        clk;
    logic                        rst_n;
    logic                        downloading;
    rom_loader_pkg::ioctl_addr_t ioctl_addr;
    logic [7:0]                  ioctl_dout;
    logic                        ioctl_wr;
    rom_loader_pkg::bank_t       sdram_rd_ba;
    logic [SDRAM_AW-1:0]         sdram_rd_addr;
    logic [PROM_AW-1:0]          prom_addr;
    rom_loader_pkg::prog_data_t  sdram_rd_data;
    logic [7:0]                  prom_dout;
    rom_loader_pkg::hdr_cfg_u    hdr_cfg;
    logic                        header;

    // reference model, four banks stacked with the bank number on top
    rom_loader_pkg::prog_data_t ref_sdram [0:(4 << SDRAM_AW)-1];
    logic [7:0]                 ref_prom [0:(1 << PROM_AW)-1];
    logic [7:0]                 ref_hdr [0:`ROM_HEADER_LEN-1];
    int                         errors;

    rom_loader_top rom_loader_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .downloading   (downloading),
        .ioctl_addr    (ioctl_addr),
        .ioctl_dout    (ioctl_dout),
        .ioctl_wr      (ioctl_wr),
        .sdram_rd_ba   (sdram_rd_ba),
        .sdram_rd_addr (sdram_rd_addr),
        .prom_addr     (prom_addr),
        .sdram_rd_data (sdram_rd_data),
        .prom_dout     (prom_dout),
        .hdr_cfg       (hdr_cfg),
        .header        (header)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_data(input string name, input rom_loader_pkg::prog_data_t got,
                              input rom_loader_pkg::prog_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_hdr(input rom_loader_pkg::hdr_cfg_u got,
                             input rom_loader_pkg::hdr_cfg_u exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: hdr_cfg is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // header bytes, PROM above the boundary, otherwise the highest bank that fits
    task automatic model_write(input rom_loader_pkg::ioctl_addr_t addr, input logic [7:0] data);
        rom_loader_pkg::ioctl_addr_t off;
        rom_loader_pkg::ioctl_addr_t in_bank;
        rom_loader_pkg::bank_t       ba;
        logic [SDRAM_AW+1:0]         idx;
        off = addr - HDR_LEN;
        if (addr < HDR_LEN) begin
            ref_hdr[addr[2:0]] = data;
        end else if (off >= PROM_START) begin
            in_bank = off - PROM_START;
            ref_prom[in_bank[PROM_AW-1:0]] = data;
        end else begin
            ba = (off >= BA3_START) ? 2'd3 : (off >= BA2_START) ? 2'd2 :
                 (off >= BA1_START) ? 2'd1 : 2'd0;
            in_bank = off - bank_base(ba);
            idx = {ba, in_bank[SDRAM_AW:1]};
            // lane picked by the byte's parity, flipped when lanes are swapped
            if (in_bank[0] ^ SWAB) ref_sdram[idx][15:8] = data;
            else ref_sdram[idx][7:0] = data;
        end
    endtask

    function automatic rom_loader_pkg::ioctl_addr_t bank_base(input rom_loader_pkg::bank_t ba);
        case (ba)
            2'd1:    return BA1_START;
            2'd2:    return BA2_START;
            2'd3:    return BA3_START;
            default: return '0;
        endcase
    endfunction

    // magic is the first two bytes, the checksum the last four, first byte on top
    function automatic rom_loader_pkg::hdr_cfg_u expected_hdr();
        rom_loader_pkg::hdr_cfg_u h;
        h.hdr_fields.magic    = {ref_hdr[0], ref_hdr[1]};
        h.hdr_fields.version  = ref_hdr[2];
        h.hdr_fields.flags    = ref_hdr[3];
        h.hdr_fields.checksum = {ref_hdr[4], ref_hdr[5], ref_hdr[6], ref_hdr[7]};
        return h;
    endfunction

    //////////////////////////////////////////////////
    // host and read port drivers
    //////////////////////////////////////////////////

    task automatic set_downloading(input logic v);
        @(posedge clk);
        #1;
        downloading = v;
    endtask

    // one host write, then the spacing of 8 cycles with the ack pulses counted
    task automatic send_byte(input rom_loader_pkg::ioctl_addr_t addr, input logic [7:0] data);
        int   acks;
        int   exp_acks;
        logic exp_hdr;
        acks = 0;
        exp_hdr = downloading && (addr < HDR_LEN);
        exp_acks = (downloading && !exp_hdr && (addr - HDR_LEN < PROM_START)) ? 1 : 0;
        @(posedge clk);
        #1;
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr = 1'b1;
        #1;
        check_bit("header", header, exp_hdr);
        if (downloading) model_write(addr, data);
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            #1;
            if (rom_loader_top_i.sdram_ack) acks++;
        end
        check_count("sdram_ack pulses", acks, exp_acks);
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        while (rom_loader_top_i.sdram_ack !== 1'b1 && n < 16) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rom_loader_top_i.sdram_ack !== 1'b1) begin
            errors++;
            $display("sdram_ack did not arrive within 16 cycles of the request");
        end
    endtask

    // every word of every bank and every PROM byte against the model
    task automatic compare_all();
        for (int a = 0; a < (4 << SDRAM_AW); a++) begin
            @(posedge clk);
            #1;
            {sdram_rd_ba, sdram_rd_addr} = (SDRAM_AW + 2)'(a);
            prom_addr = PROM_AW'(a);
            @(posedge clk);
            #1;
            check_data($sformatf("sdram_rd_data[%0d][%0h]", sdram_rd_ba, sdram_rd_addr),
                       sdram_rd_data, ref_sdram[a]);
            if (a < (1 << PROM_AW)) check_byte($sformatf("prom_dout[%0h]", prom_addr),
                                               prom_dout, ref_prom[a]);
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic reset_values();
        check_bit("header", header, 1'b0);
        check_hdr(hdr_cfg, '0);
        compare_all();
    endtask

    task automatic header_capture();
        logic [7:0] hdr_data [0:7] = '{8'h5a, 8'ha5, 8'h02, 8'h81, 8'hde, 8'had, 8'hbe, 8'hef};
        set_downloading(1'b1);
        for (int i = 0; i < 8; i++) send_byte(HDR_LEN - 25'(8 - i), hdr_data[i]);
        check_hdr(hdr_cfg, expected_hdr());
        compare_all();
    endtask

    // a full word, then a lone odd byte, in each bank
    task automatic bank_writes();
        rom_loader_pkg::ioctl_addr_t base;
        for (int b = 0; b < 4; b++) begin
            base = HDR_LEN + bank_base(2'(b));
            send_byte(base + 25'(2 * (b + 3)), 8'(16 * b + 1));
            send_byte(base + 25'(2 * (b + 3) + 1), 8'(16 * b + 2));
            send_byte(base + 25'h41, 8'(16 * b + 3));
        end
        set_downloading(1'b0);
        compare_all();
    endtask

    task automatic prom_writes();
        set_downloading(1'b1);
        send_byte(HDR_LEN + PROM_START, 8'h9c);
        send_byte(HDR_LEN + PROM_START + 25'h01, 8'h3e);
        send_byte(HDR_LEN + PROM_START + 25'h33, 8'h71);
        send_byte(HDR_LEN + PROM_START + 25'h7f, 8'he4);
        set_downloading(1'b0);
        compare_all();
    endtask

    // the port has already taken the request when downloading falls
    task automatic download_abort();
        set_downloading(1'b1);
        @(posedge clk);
        #1;
        ioctl_addr = HDR_LEN + BA2_START + 25'h50;
        ioctl_dout = 8'h3c;
        ioctl_wr = 1'b1;
        model_write(ioctl_addr, ioctl_dout);
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        check_bit("prog_we", rom_loader_top_i.prog_we, 1'b1);
        downloading = 1'b0;
        @(posedge clk);
        #1;
        check_bit("prog_we", rom_loader_top_i.prog_we, 1'b0);
        wait_ack();
        // writes outside a download are ignored everywhere
        send_byte(HDR_LEN + 25'h12, 8'hff);
        send_byte(HDR_LEN + PROM_START + 25'h05, 8'hff);
        send_byte(25'h3, 8'hff);
        check_bit("prom_we", rom_loader_top_i.prom_we, 1'b0);
        check_hdr(hdr_cfg, expected_hdr());
        compare_all();
    endtask

    task automatic random_download();
        int unsigned off;
        set_downloading(1'b1);
        for (int i = 0; i < 8; i++) send_byte(25'(i), 8'($urandom));
        for (int i = 0; i < 24; i++) begin
            off = $urandom_range(`ROM_PROM_START - 1, 0);
            send_byte(HDR_LEN + 25'(off), 8'($urandom));
        end
        for (int i = 0; i < 8; i++) begin
            off = $urandom_range((1 << PROM_AW) - 1, 0);
            send_byte(HDR_LEN + PROM_START + 25'(off), 8'($urandom));
        end
        set_downloading(1'b0);
        check_hdr(hdr_cfg, expected_hdr());
        compare_all();
    endtask

    initial begin
        errors = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_wr = 1'b0;
        sdram_rd_ba = '0;
        sdram_rd_addr = '0;
        prom_addr = '0;
        void'($urandom(32'h61199827));
        foreach (ref_sdram[i]) ref_sdram[i] = '0;
        foreach (ref_prom[i]) ref_prom[i] = '0;
        foreach (ref_hdr[i]) ref_hdr[i] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_values();
        header_capture();
        bank_writes();
        prom_writes();
        download_abort();
        random_download();
        errors += rom_loader_top_i.rom_dwnld_i.chk_i.fails;
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verilog/hdr_regs.sv
`timescale 1ns/10ps
`include "rom_loader_settings.svh"

module hdr_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        header,
    input  logic                        ioctl_wr,
    input  rom_loader_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]                  ioctl_dout,
    output rom_loader_pkg::hdr_cfg_u    hdr_cfg
);

    // enough address bits to pick one header byte
    localparam int IDX_W = $clog2(`ROM_HEADER_LEN);

    logic [IDX_W-1:0] byte_idx;
    logic             hdr_wr;

    assign byte_idx = ioctl_addr[IDX_W-1:0];

    // header already implies downloading and an address inside the header
    assign hdr_wr = header && ioctl_wr;

    //////////////////////////////////////////////////
    // header capture
    //////////////////////////////////////////////////

    // the byte view is filled here and the fields are read by the game side
    // nothing clears it when the download ends, so the settings
    // stay available until the next reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_cfg <= '0;
        end else if (hdr_wr) begin
            hdr_cfg.hdr_bytes[byte_idx] <= ioctl_dout;
        end
    end

endmodule

// File: verilog/prom_store.sv
`timescale 1ns/10ps
`include "rom_loader_settings.svh"

module prom_store (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`ROM_PROM_AW-1:0] wr_addr,
    input  logic [7:0]             wr_data,
    input  logic [`ROM_PROM_AW-1:0] rd_addr,
    output logic [7:0]             rd_data
);

    localparam int DEPTH = 1 << `ROM_PROM_AW;

    logic [7:0] mem [0:DEPTH-1];

    // cleared contents at power up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // we can stay high for several cycles, which only rewrites the same byte
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // game side read port with one cycle of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/rom_dwnld.sv
`timescale 1ns/10ps
`include "rom_loader_settings.svh"

module rom_dwnld (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  rom_loader_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]                 ioctl_dout,
    input  logic                       ioctl_wr,
    input  logic                       sdram_ack,
    output rom_loader_pkg::prog_addr_t prog_addr,
    output rom_loader_pkg::prog_data_t prog_data,
    output rom_loader_pkg::byte_mask_t prog_mask,
    output logic                       prog_we,
    output rom_loader_pkg::bank_t      prog_ba,
    output logic                       prom_we,
    output logic                       header
);

    localparam rom_loader_pkg::ioctl_addr_t HDR_LEN    = `ROM_HEADER_LEN;
    localparam rom_loader_pkg::ioctl_addr_t BA1_START  = `ROM_BA1_START;
    localparam rom_loader_pkg::ioctl_addr_t BA2_START  = `ROM_BA2_START;
    localparam rom_loader_pkg::ioctl_addr_t BA3_START  = `ROM_BA3_START;
    localparam rom_loader_pkg::ioctl_addr_t PROM_START = `ROM_PROM_START;
    localparam logic                        SWAB       = 1'(`ROM_SWAB);

    // last byte taken from the host
    logic [7:0] data_q;

    rom_loader_pkg::ioctl_addr_t part_addr;
    rom_loader_pkg::ioctl_addr_t bank_start;
    rom_loader_pkg::ioctl_addr_t eff_addr;
    rom_loader_pkg::ioctl_addr_t prom_off;
    rom_loader_pkg::bank_t       bank;
    logic                        is_prom;
    logic                        byte_ok;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    // header bytes are captured elsewhere, so they never reach SDRAM or PROM
    assign header  = downloading && (ioctl_addr < HDR_LEN);
    assign byte_ok = ioctl_wr && downloading && !header;

    // offset into the image body, the header is removed first
    assign part_addr = ioctl_addr - HDR_LEN;
    assign is_prom   = part_addr >= PROM_START;
    assign prom_off  = part_addr - PROM_START;

    // the highest bank whose start is not above the offset wins
    always_comb begin
        if (part_addr >= BA3_START) begin
            bank       = 2'd3;
            bank_start = BA3_START;
        end else if (part_addr >= BA2_START) begin
            bank       = 2'd2;
            bank_start = BA2_START;
        end else if (part_addr >= BA1_START) begin
            bank       = 2'd1;
            bank_start = BA1_START;
        end else begin
            bank       = 2'd0;
            bank_start = '0;
        end
    end

    assign eff_addr = part_addr - bank_start;

    // the SDRAM picks the right half through the mask
    assign prog_data = {2{data_q}};

    //////////////////////////////////////////////////
    // write strobes
    //////////////////////////////////////////////////

    // prog_we is held until the SDRAM port acknowledges it
    // prom_we stays up until an SDRAM byte arrives or the download ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else if (byte_ok) begin
            prog_we <= !is_prom;
            prom_we <= is_prom;
        end else begin
            if (!downloading || sdram_ack) prog_we <= 1'b0;
            if (!downloading) prom_we <= 1'b0;
        end
    end

    // request payload, only meaningful while a strobe is high
    always_ff @(posedge clk) begin
        if (byte_ok) begin
            data_q <= ioctl_dout;
            if (is_prom) begin
                prog_addr <= prom_off[21:0];
            end else begin
                prog_addr <= eff_addr[22:1];
                prog_ba   <= bank;
            end
            // even in-bank offsets go to the low lane unless swapped
            prog_mask <= (eff_addr[0] ^ SWAB) ? 2'b01 : 2'b10;
        end
    end

endmodule

// File: verilog/rom_loader_pkg.sv
`include "rom_loader_settings.svh"

package rom_loader_pkg;

    // byte address as seen by the host during the download
    typedef logic [24:0] ioctl_addr_t;

    // word address for SDRAM writes, byte address for PROM writes
    typedef logic [21:0] prog_addr_t;

    // one of the four SDRAM banks
    typedef logic [1:0] bank_t;

    // SDRAM data word, the same byte is placed in both lanes
    typedef logic [15:0] prog_data_t;

    // active low lane enables, bit 0 is the low byte
    typedef logic [1:0] byte_mask_t;

    // the header is filled byte by byte but read as named fields
    // byte 0 sits in the top bits, so magic is {byte 0, byte 1}
    // and the checksum is bytes 4 to 7 with byte 4 most significant
    typedef union packed {
        logic [0:`ROM_HEADER_LEN-1][7:0] hdr_bytes;
        struct packed {
            logic [15:0] magic;
            logic [7:0]  version;
            logic [7:0]  flags;
            logic [31:0] checksum;
        } hdr_fields;
    } hdr_cfg_u;

endpackage

// File: verilog/rom_loader_settings.svh
`ifndef ROM_LOADER_SETTINGS_SVH
`define ROM_LOADER_SETTINGS_SVH

//////////////////////////////////////////////////
// image layout
//////////////////////////////////////////////////

// number of bytes at the start of the image that form the header
`define ROM_HEADER_LEN 8

// bank starts, counted from the first byte after the header
`define ROM_BA1_START 'h100
`define ROM_BA2_START 'h200
`define ROM_BA3_START 'h300

// everything at or above this offset after the header goes to the PROM
`define ROM_PROM_START 'h380

// set to 1 so that every pair of SDRAM bytes lands with its lanes swapped
`define ROM_SWAB 1

//////////////////////////////////////////////////
// store sizes and timing
//////////////////////////////////////////////////

// word address width of one SDRAM bank, so 128 words per bank
`define ROM_SDRAM_AW 7
// byte address width of the PROM
`define ROM_PROM_AW 7
// cycles from the sampled write request to the ack pulse
`define ROM_ACK_LAT 3

`endif

// File: verilog/rom_loader_top.sv
`timescale 1ns/10ps
`include "rom_loader_settings.svh"

module rom_loader_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  rom_loader_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]                  ioctl_dout,
    input  logic                        ioctl_wr,
    input  rom_loader_pkg::bank_t       sdram_rd_ba,
    input  logic [`ROM_SDRAM_AW-1:0]    sdram_rd_addr,
    input  logic [`ROM_PROM_AW-1:0]     prom_addr,
    output rom_loader_pkg::prog_data_t  sdram_rd_data,
    output logic [7:0]                  prom_dout,
    output rom_loader_pkg::hdr_cfg_u    hdr_cfg,
    output logic                        header
);

    // SDRAM programming request and its ack
    rom_loader_pkg::prog_addr_t prog_addr;
    rom_loader_pkg::prog_data_t prog_data;
    rom_loader_pkg::byte_mask_t prog_mask;
    rom_loader_pkg::bank_t      prog_ba;
    logic                       prog_we;
    logic                       sdram_ack;
    // PROM shares the address and data of the request
    logic                       prom_we;

    //////////////////////////////////////////////////
    // download splitter and header capture
    //////////////////////////////////////////////////

    rom_dwnld rom_dwnld_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prog_ba     (prog_ba),
        .prom_we     (prom_we),
        .header      (header)
    );

    hdr_regs hdr_regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .header     (header),
        .ioctl_wr   (ioctl_wr),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .hdr_cfg    (hdr_cfg)
    );

    //////////////////////////////////////////////////
    // memories
    //////////////////////////////////////////////////

    sdram_prog sdram_prog_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_mask (prog_mask),
        .prog_ba   (prog_ba),
        .rd_ba     (sdram_rd_ba),
        .rd_addr   (sdram_rd_addr),
        .sdram_ack (sdram_ack),
        .rd_data   (sdram_rd_data)
    );

    // both lanes carry the same byte, so the low one is enough
    prom_store prom_store_i (
        .clk     (clk),
        .we      (prom_we),
        .wr_addr (prog_addr[`ROM_PROM_AW-1:0]),
        .wr_data (prog_data[7:0]),
        .rd_addr (prom_addr),
        .rd_data (prom_dout)
    );

endmodule

// File: verilog/sdram_prog.sv
`timescale 1ns/10ps
`include "rom_loader_settings.svh"

module sdram_prog (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       prog_we,
    input  rom_loader_pkg::prog_addr_t prog_addr,
    input  rom_loader_pkg::prog_data_t prog_data,
    input  rom_loader_pkg::byte_mask_t prog_mask,
    input  rom_loader_pkg::bank_t      prog_ba,
    input  rom_loader_pkg::bank_t      rd_ba,
    input  logic [`ROM_SDRAM_AW-1:0]   rd_addr,
    output logic                       sdram_ack,
    output rom_loader_pkg::prog_data_t rd_data
);

    localparam int CNT_W = $clog2(`ROM_ACK_LAT + 1);
    localparam int IDX_W = `ROM_SDRAM_AW + 2;
    localparam int DEPTH = 1 << IDX_W;

    // four banks stacked one after the other, bank number on top
    rom_loader_pkg::prog_data_t mem [0:DEPTH-1];

    logic                       prog_we_q;
    logic                       busy;
    logic [CNT_W-1:0]           cnt;
    logic                       start;
    logic                       done;
    logic [IDX_W-1:0]           wr_idx_q;
    rom_loader_pkg::prog_data_t data_q;
    rom_loader_pkg::byte_mask_t mask_q;

    // a request is taken on the rising edge of prog_we only
    assign start = prog_we && !prog_we_q && !busy;
    assign done  = busy && (cnt == '0);

    //////////////////////////////////////////////////
    // latency emulation
    //////////////////////////////////////////////////

    // the counter starts one short because the write itself takes an edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we_q <= 1'b0;
            busy      <= 1'b0;
            cnt       <= '0;
            sdram_ack <= 1'b0;
        end else begin
            prog_we_q <= prog_we;
            sdram_ack <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`ROM_ACK_LAT - 1);
            end else if (done) begin
                busy      <= 1'b0;
                sdram_ack <= 1'b1;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // request held here so the loader may change its outputs early
    always_ff @(posedge clk) begin
        if (start) begin
            wr_idx_q <= {prog_ba, prog_addr[`ROM_SDRAM_AW-1:0]};
            data_q   <= prog_data;
            mask_q   <= prog_mask;
        end
    end

    //////////////////////////////////////////////////
    // word store
    //////////////////////////////////////////////////

    // the store powers up cleared, as a block RAM with an init value would
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // only lanes with a low mask bit are written
    always_ff @(posedge clk) begin
        if (done) begin
            if (!mask_q[0]) mem[wr_idx_q][7:0]  <= data_q[7:0];
            if (!mask_q[1]) mem[wr_idx_q][15:8] <= data_q[15:8];
        end
    end

    // registered read, data shows up one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[{rd_ba, rd_addr}];
    end

endmodule
